/* hw/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic                             instrValid,
   input  logic [isaPkg::dataWidth-1:0]    instr,
   output logic [isaPkg::regAddrWidth-1:0] readAddrA,
   output logic [isaPkg::regAddrWidth-1:0] readAddrB,
   input  logic [isaPkg::dataWidth-1:0]    readDataA,
   input  logic [isaPkg::dataWidth-1:0]    readDataB,
   input  logic                             xValid,
   input  logic [isaPkg::regAddrWidth-1:0] xWrtReg,
   input  logic [isaPkg::dataWidth-1:0]    aluResult,
   input  logic                             wValid,
   input  logic [isaPkg::regAddrWidth-1:0] wWrtReg,
   input  logic [isaPkg::dataWidth-1:0]    wResult,
   output logic                             decValid,
   output pipePkg::decodeWordT              decWord
);

   import isaPkg::*;
   import pipePkg::*;

   logic [opWidth-1:0]      opcode;
   logic [regAddrWidth-1:0] rdAddr;
   logic [regAddrWidth-1:0] rsAddr;
   logic [regAddrWidth-1:0] rtAddr;
   logic [imm6Width-1:0]    imm6;
   logic [imm8Width-1:0]    imm8;

   aluOpT                   aluOp;
   logic                    writes;     // opcode updates rd
   logic [1:0]              bSel;       // 0 rt, 1 sext imm6, 2 sext imm8, 3 zext imm8
   logic [dataWidth-1:0]    regA;
   logic [dataWidth-1:0]    regB;
   logic [dataWidth-1:0]    immB;

   // field split
   assign opcode = instr[opHi:opLo];
   assign rdAddr = instr[rdHi:rdLo];
   assign rsAddr = instr[rsHi:rsLo];
   assign rtAddr = instr[rtHi:rtLo];
   assign imm6   = instr[imm6Width-1:0];
   assign imm8   = instr[imm8Width-1:0];

   always_comb begin
      aluOp  = aluAdd;
      writes = 1'b1;
      bSel   = 2'd0;
      case (opcode)
         opAdd:  aluOp = aluAdd;
         opSub:  aluOp = aluSub;
         opAnd:  aluOp = aluAnd;
         opOr:   aluOp = aluOr;
         opXor:  aluOp = aluXor;
         opSll:  aluOp = aluSll;
         opSrl:  aluOp = aluSrl;
         opAddi: begin
            aluOp = aluAdd;
            bSel  = 2'd1;
         end
         opLbi: begin
            aluOp = aluPassB;
            bSel  = 2'd2;
         end
         opSlbi: begin
            aluOp = aluSlbi;
            bSel  = 2'd3;
         end
         default: writes = 1'b0;  // reserved
      endcase
   end

   // SLBI reads back its own destination
   assign readAddrA = (opcode == opSlbi) ? rdAddr : rsAddr;
   assign readAddrB = rtAddr;

   // execute result wins over writeback, then the register file
   assign regA = (xValid && xWrtReg == readAddrA) ? aluResult :
                 (wValid && wWrtReg == readAddrA) ? wResult : readDataA;
   assign regB = (xValid && xWrtReg == readAddrB) ? aluResult :
                 (wValid && wWrtReg == readAddrB) ? wResult : readDataB;

   always_comb begin
      case (bSel)
         2'd1:    immB = {{(dataWidth-imm6Width){imm6[imm6Width-1]}}, imm6};
         2'd2:    immB = {{(dataWidth-imm8Width){imm8[imm8Width-1]}}, imm8};
         default: immB = {{(dataWidth-imm8Width){1'b0}}, imm8};
      endcase
   end

   always_comb begin
      decWord.aluOp  = aluOp;
      decWord.opA    = regA;
      decWord.opB    = (bSel == 2'd0) ? regB : immB;
      decWord.wrtReg = rdAddr;
   end

   assign decValid = instrValid & writes;  // no-ops never enter the pipe

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  pipePkg::aluOpT                aluOp,
   input  logic [isaPkg::dataWidth-1:0] opA,
   input  logic [isaPkg::dataWidth-1:0] opB,
   output logic [isaPkg::dataWidth-1:0] aluResult
);

   import isaPkg::*;
   import pipePkg::*;

   logic [$clog2(dataWidth)-1:0] shamt;
   logic [dataWidth-1:0]         slbiVal;

   assign shamt = opB[$clog2(dataWidth)-1:0];  // low 4 bits of rt

   // old rd moves up a byte, immediate already zero extended
   assign slbiVal = {opA[dataWidth-imm8Width-1:0], {imm8Width{1'b0}}} | opB;

   always_comb begin
      case (aluOp)
         aluAdd:   aluResult = opA + opB;  // wraps mod 2^16
         aluSub:   aluResult = opA - opB;
         aluAnd:   aluResult = opA & opB;
         aluOr:    aluResult = opA | opB;
         aluXor:   aluResult = opA ^ opB;
         aluSll:   aluResult = opA << shamt;
         aluSrl:   aluResult = opA >> shamt;  // logical
         aluPassB: aluResult = opB;
         aluSlbi:  aluResult = slbiVal;
         default:  aluResult = '0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

   // datapath widths
   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int regCount     = 8;

   localparam int opWidth = 4;

   // opcodes, instr[15:12]
   localparam logic [opWidth-1:0] opAdd  = 4'd0;
   localparam logic [opWidth-1:0] opSub  = 4'd1;
   localparam logic [opWidth-1:0] opAnd  = 4'd2;
   localparam logic [opWidth-1:0] opOr   = 4'd3;
   localparam logic [opWidth-1:0] opXor  = 4'd4;
   localparam logic [opWidth-1:0] opSll  = 4'd5;
   localparam logic [opWidth-1:0] opSrl  = 4'd6;
   localparam logic [opWidth-1:0] opAddi = 4'd7;
   localparam logic [opWidth-1:0] opLbi  = 4'd8;
   localparam logic [opWidth-1:0] opSlbi = 4'd9;
   // 10..15 reserved, decode as no-ops

   // instruction field positions
   localparam int opHi = 15;
   localparam int opLo = 12;
   localparam int rdHi = 11;
   localparam int rdLo = 9;
   localparam int rsHi = 8;
   localparam int rsLo = 6;
   localparam int rtHi = 5;
   localparam int rtLo = 3;

   // immediates sit at the bottom of the word
   localparam int imm6Width = 6;  // sign extended
   localparam int imm8Width = 8;  // sext for LBI, zext for SLBI

endpackage

`default_nettype wire

/* hw/pipeCore.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             instrValid,
   input  logic [isaPkg::dataWidth-1:0]    instr,
   output logic                             resultValid,
   output logic [isaPkg::dataWidth-1:0]    result,
   output logic [isaPkg::regAddrWidth-1:0] resultReg
);

   import isaPkg::*;
   import pipePkg::*;

   logic [regAddrWidth-1:0] readAddrA;
   logic [regAddrWidth-1:0] readAddrB;
   logic [dataWidth-1:0]    readDataA;
   logic [dataWidth-1:0]    readDataB;

   // decode side
   logic       decValid;
   decodeWordT decWord;

   // execute side
   logic                 xValid;
   decodeWordT           xWord;
   logic [dataWidth-1:0] aluResult;
   execWordT             xOut;

   // writeback side
   logic     wValid;
   execWordT wWord;

   regFile i_regFile (
      .clk       (clk),
      .reset     (reset),
      .readAddrA (readAddrA),
      .readAddrB (readAddrB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .writeEn   (wValid),
      .writeAddr (wWord.wrtReg),
      .writeData (wWord.result)
   );

   decodeStage i_decode (
      .instrValid (instrValid),
      .instr      (instr),
      .readAddrA  (readAddrA),
      .readAddrB  (readAddrB),
      .readDataA  (readDataA),
      .readDataB  (readDataB),
      .xValid     (xValid),
      .xWrtReg    (xWord.wrtReg),
      .aluResult  (aluResult),
      .wValid     (wValid),
      .wWrtReg    (wWord.wrtReg),
      .wResult    (wWord.result),
      .decValid   (decValid),
      .decWord    (decWord)
   );

   pipeReg #(.payloadT(decodeWordT)) d2xReg (
      .clk      (clk),
      .reset    (reset),
      .inValid  (decValid),
      .inData   (decWord),
      .outValid (xValid),
      .outData  (xWord)
   );

   executeStage i_execute (
      .aluOp     (xWord.aluOp),
      .opA       (xWord.opA),
      .opB       (xWord.opB),
      .aluResult (aluResult)
   );

   // result rides with its destination into writeback
   assign xOut.result = aluResult;
   assign xOut.wrtReg = xWord.wrtReg;

   pipeReg #(.payloadT(execWordT)) x2wReg (
      .clk      (clk),
      .reset    (reset),
      .inValid  (xValid),
      .inData   (xOut),
      .outValid (wValid),
      .outData  (wWord)
   );

   assign resultValid = wValid;
   assign result      = wWord.result;
   assign resultReg   = wWord.wrtReg;

endmodule

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

   // operations the execute stage knows about
   typedef enum logic [3:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluAnd   = 4'd2,
      aluOr    = 4'd3,
      aluXor   = 4'd4,
      aluSll   = 4'd5,
      aluSrl   = 4'd6,
      aluPassB = 4'd7,  // LBI
      aluSlbi  = 4'd8
   } aluOpT;

   // decode -> execute, 39 bits
   typedef struct packed {
      aluOpT                              aluOp;
      logic [isaPkg::dataWidth-1:0]    opA;
      logic [isaPkg::dataWidth-1:0]    opB;
      logic [isaPkg::regAddrWidth-1:0] wrtReg;
   } decodeWordT;

   // execute -> writeback, 19 bits
   typedef struct packed {
      logic [isaPkg::dataWidth-1:0]    result;
      logic [isaPkg::regAddrWidth-1:0] wrtReg;
   } execWordT;

endpackage

`default_nettype wire

/* hw/pipeReg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    inValid,
   input  payloadT inData,
   output logic    outValid,
   output payloadT outData
);

   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else begin
         outValid <= inValid;  // bubble passes through as 0
      end
   end

   // data only moves with a valid entry
   always_ff @(posedge clk) begin
      if (inValid) begin
         outData <= inData;
      end
   end

endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [isaPkg::regAddrWidth-1:0] readAddrA,
   input  logic [isaPkg::regAddrWidth-1:0] readAddrB,
   output logic [isaPkg::dataWidth-1:0]    readDataA,
   output logic [isaPkg::dataWidth-1:0]    readDataB,
   input  logic                             writeEn,
   input  logic [isaPkg::regAddrWidth-1:0] writeAddr,
   input  logic [isaPkg::dataWidth-1:0]    writeData
);

   import isaPkg::*;

   logic [dataWidth-1:0] regs [regCount];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeAddr] <= writeData;
      end
   end

   // plain async reads, forwarding lives in decode
   assign readDataA = regs[readAddrA];
   assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the pipeCore testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module pipeCoreTb -f src.f -o simv \
   > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* src.f */
hw/isaPkg.sv
hw/pipePkg.sv
hw/regFile.sv
hw/decodeStage.sv
hw/pipeReg.sv
hw/executeStage.sv
hw/pipeCore.sv
test/pipeCore_chk.sv
test/pipeCoreTb.sv

/* test/pipeCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCoreTb;

   import isaPkg::*;

   localparam int clkPeriod     = 40;
   localparam int resetCycles   = 10;
   localparam int directedCount = 12;
   localparam int randomCount   = 400;
   localparam int instrCount    = directedCount + randomCount;

   logic        clk;
   logic        reset;
   logic        instrValid;
   logic [15:0] instr;
   logic        resultValid;
   logic [15:0] result;
   logic [2:0]  resultReg;

   logic [15:0] model [8];  // architectural registers, in program order
   logic [15:0] expResult [$];
   logic [2:0]  expReg [$];
   int          expCycle [$];
   int          cycle;
   int          seed;
   int          checks;
   int          errors;

   pipeCore i_dut (
      .clk         (clk),
      .reset       (reset),
      .instrValid  (instrValid),
      .instr       (instr),
      .resultValid (resultValid),
      .result      (result),
      .resultReg   (resultReg)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic logic [15:0] encodeReg(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [2:0] rs, input logic [2:0] rt);
      return {op, rd, rs, rt, 3'b000};
   endfunction

   function automatic logic [15:0] encodeImm(input logic [3:0] op, input logic [2:0] rd,
                                             input logic [8:0] low);
      return {op, rd, low};
   endfunction

   // reference ALU straight from the ISA rules
   function automatic logic [15:0] modelAlu(input logic [15:0] ins);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      a = model[ins[8:6]];
      b = model[ins[5:3]];
      case (ins[15:12])
         opAdd:   r = a + b;
         opSub:   r = a - b;
         opAnd:   r = a & b;
         opOr:    r = a | b;
         opXor:   r = a ^ b;
         opSll:   r = a << b[3:0];
         opSrl:   r = a >> b[3:0];
         opAddi:  r = a + {{10{ins[5]}}, ins[5:0]};
         opLbi:   r = {{8{ins[7]}}, ins[7:0]};
         opSlbi:  r = {model[ins[11:9]][7:0], ins[7:0]};
         default: r = 16'h0000;
      endcase
      return r;
   endfunction

   // one input cycle, model advances when the instruction writes
   task automatic issue(input logic v, input logic [15:0] ins);
      logic [15:0] r;
      @(posedge clk);
      instrValid <= v;
      instr      <= ins;
      if (v && ins[15:12] <= opSlbi) begin
         r = modelAlu(ins);
         model[ins[11:9]] = r;
         expResult.push_back(r);
         expReg.push_back(ins[11:9]);
         expCycle.push_back(cycle + 3);  // strobe cycle is cycle + 1
      end
   endtask

   // outputs sampled mid-cycle
   always @(negedge clk) begin
      cycle = cycle + 1;
      while (expCycle.size() > 0 && expCycle[0] < cycle) begin
         errors++;
         $display("ERROR: result for r%0d due in cycle %0d never arrived",
                  expReg[0], expCycle[0]);
         void'(expResult.pop_front());
         void'(expReg.pop_front());
         void'(expCycle.pop_front());
      end
      if (resultValid === 1'b1) begin
         if (expReg.size() == 0) begin
            errors++;
            $display("ERROR: resultValid at %0t with no instruction in flight", $time);
         end else begin
            compareValue(32'(cycle), 32'(expCycle[0]), "arrival cycle");
            compareValue(32'(resultReg), 32'(expReg[0]), "resultReg");
            compareValue(32'(result), 32'(expResult[0]), "result");
            void'(expResult.pop_front());
            void'(expReg.pop_front());
            void'(expCycle.pop_front());
         end
      end
   end

   initial begin
      #((resetCycles + instrCount + 20) * clkPeriod);
      $display("TIMEOUT: run did not finish in the expected time");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      logic v;
      seed       = 8301;
      cycle      = 0;
      checks     = 0;
      errors     = 0;
      reset      = 1'b1;
      instrValid = 1'b0;
      instr      = 16'h0000;
      for (int i = 0; i < 8; i++) begin
         model[i] = 16'h0000;
      end
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;

      issue(1'b1, encodeReg(opAdd, 3'd3, 3'd5, 3'd2));     // regs still zero
      issue(1'b1, encodeImm(opLbi, 3'd1, 9'h085));          // sext to ff85
      issue(1'b1, encodeImm(opSlbi, 3'd1, 9'h03c));         // needs r1 from execute
      issue(1'b1, encodeImm(opAddi, 3'd2, {3'd1, 6'h3d}));  // r1 - 3
      issue(1'b0, 16'h0000);
      issue(1'b1, encodeReg(opSub, 3'd4, 3'd2, 3'd1));      // r2 two slots back
      issue(1'b1, encodeImm(4'hc, 3'd4, 9'h1ff));           // reserved, no write
      issue(1'b1, encodeReg(opSll, 3'd5, 3'd1, 3'd2));
      issue(1'b1, encodeReg(opSrl, 3'd6, 3'd1, 3'd2));
      issue(1'b1, encodeReg(opXor, 3'd7, 3'd5, 3'd6));
      issue(1'b1, encodeReg(opAnd, 3'd0, 3'd7, 3'd4));
      issue(1'b1, encodeReg(opOr, 3'd3, 3'd0, 3'd1));

      for (int i = 0; i < randomCount; i++) begin
         v = ($unsigned($random(seed)) % 100) < 70;  // about 70% busy
         issue(v, 16'($random(seed)));
      end
      repeat (5) issue(1'b0, 16'h0000);  // drain the pipe

      if (expReg.size() != 0) begin
         errors++;
         $display("ERROR: %0d expected results still pending at end of run", expReg.size());
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/pipeCore_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCore_chk (
   input logic clk,
   input logic reset,
   input logic instrValid,
   input logic resultValid
);

   // every result traces back to a strobe two cycles earlier
   strobeOrigin: assert property (@(posedge clk) disable iff (reset)
      resultValid |-> $past(instrValid, 2))
      else $error("resultValid without instrValid two cycles earlier");

   // quiet in reset and while the pipe refills
   quietAfterReset: assert property (@(posedge clk)
      ($past(reset) || $past(reset, 2)) |-> !resultValid)
      else $error("resultValid high during or just after reset");

   knownStrobe: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(resultValid))
      else $error("resultValid is unknown");

endmodule

bind pipeCore pipeCore_chk i_chk (
   .clk         (clk),
   .reset       (reset),
   .instrValid  (instrValid),
   .resultValid (resultValid)
);

`default_nettype wire
